/* rtl/masku_pkg.sv */
// Sizes, derived widths and opcodes of the four-lane mask unit, imported by each RTL block
`default_nettype none

package masku_pkg;

  ////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////

  // Lanes of the vector processor
  localparam int unsigned NrLanes   = 4;
  // Bits of one lane word
  localparam int unsigned LaneWidth = 64;
  // Byte strobes of one lane word
  localparam int unsigned LaneStrb  = LaneWidth / 8;

  // A beat spans all lanes, lane l holding bits 64*l up to 64*l+63
  localparam int unsigned BeatWidth = NrLanes * LaneWidth;
  localparam int unsigned BeatStrb  = NrLanes * LaneStrb;
  // Bit index to beat index
  localparam int unsigned BeatShift = $clog2(BeatWidth);

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Vector length, 1 up to 1024 bits
  localparam int unsigned VlWidth      = 11;
  // Beat counter, holds 0 up to 4 beats
  localparam int unsigned BeatCntWidth = 3;
  // Destination register index
  localparam int unsigned VdWidth      = 5;
  // Address words per vector register
  localparam int unsigned VregWords    = 4;
  // Register-file word address, vd * 4 + beat
  localparam int unsigned AddrWidth    = 7;
  // Instruction id
  localparam int unsigned IdWidth      = 3;
  localparam int unsigned OpWidth      = 3;

  ////////////////////////////////////////
  // Result queue
  ////////////////////////////////////////

  localparam int unsigned ResultDepth = 2;
  localparam int unsigned RqPtrWidth  = $clog2(ResultDepth);

  // Mask-logical opcodes, operand a is vs2 and operand b is vs1
  typedef enum logic [OpWidth-1:0] {
    VMAND,
    VMNAND,
    VMANDN,
    VMXOR,
    VMOR,
    VMNOR,
    VMORN,
    VMXNOR
  } mask_op_e;

endpackage

`default_nettype wire

/* rtl/masku_insn_ctrl.sv */
// Mask unit instruction control, holds one instruction and counts issued and committed beats
`timescale 1ns/1ps
`default_nettype none

module masku_insn_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Sequencer request
  input  logic                                  req_valid_i,
  input  masku_pkg::mask_op_e                   req_op_i,
  input  logic [masku_pkg::VlWidth-1:0]         req_vl_i,
  input  logic [masku_pkg::VdWidth-1:0]         req_vd_i,
  input  logic                                  req_vm_i,
  input  logic [masku_pkg::IdWidth-1:0]         req_id_i,
  output logic                                  req_ready_o,
  // Issue conditions
  input  logic                                  operands_valid_i,
  input  logic                                  queue_full_i,
  output logic                                  issue_o,
  // Current instruction and beat
  output masku_pkg::mask_op_e                   op_o,
  output logic [masku_pkg::VlWidth-1:0]         vl_o,
  output logic                                  vm_o,
  output logic [masku_pkg::BeatCntWidth-1:0]    beat_o,
  output logic [masku_pkg::AddrWidth-1:0]       addr_o,
  output logic [masku_pkg::IdWidth-1:0]         id_o,
  // Commit side
  input  logic                                  pop_i,
  output logic                                  done_o,
  output logic [masku_pkg::IdWidth-1:0]         done_id_o
);
  import masku_pkg::*;

  // Control state
  logic                    busy_q;
  logic [BeatCntWidth-1:0] nr_beats_q;
  logic [BeatCntWidth-1:0] issue_cnt_q;
  logic [BeatCntWidth-1:0] commit_cnt_q;
  logic                    done_q;

  // Instruction payload
  mask_op_e                op_q;
  logic [VlWidth-1:0]      vl_q;
  logic [VdWidth-1:0]      vd_q;
  logic                    vm_q;
  logic [IdWidth-1:0]      id_q;
  logic [IdWidth-1:0]      done_id_q;

  logic                    accept;
  logic                    last_commit;
  logic [VlWidth:0]        vl_round;
  logic [BeatCntWidth-1:0] nr_beats_d;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Only one instruction in flight
  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  // Beats per instruction, vl / 256 rounded up
  assign vl_round   = {1'b0, req_vl_i} + (VlWidth + 1)'(BeatWidth - 1);
  assign nr_beats_d = BeatCntWidth'(vl_round >> BeatShift);

  // Issue while beats remain, operands are there and the queue has room
  assign issue_o = busy_q && (issue_cnt_q != nr_beats_q) &&
                   operands_valid_i && !queue_full_i;

  // The entry holding the last beat leaves the queue
  assign last_commit = busy_q && pop_i &&
                       ((commit_cnt_q + BeatCntWidth'(1)) == nr_beats_q);

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      nr_beats_q   <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_q       <= 1'b0;
    end else begin
      // Done follows the last pop by one cycle
      done_q <= last_commit;
      if (accept) begin
        busy_q       <= 1'b1;
        nr_beats_q   <= nr_beats_d;
        issue_cnt_q  <= '0;
        commit_cnt_q <= '0;
      end else begin
        if (issue_o) begin
          issue_cnt_q <= issue_cnt_q + BeatCntWidth'(1);
        end
        if (busy_q && pop_i) begin
          commit_cnt_q <= commit_cnt_q + BeatCntWidth'(1);
        end
        // Free for a new request together with the done pulse
        if (last_commit) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Instruction fields, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= req_op_i;
      vl_q <= req_vl_i;
      vd_q <= req_vd_i;
      vm_q <= req_vm_i;
      id_q <= req_id_i;
    end
    if (last_commit) begin
      done_id_q <= id_q;
    end
  end

  assign op_o      = op_q;
  assign vl_o      = vl_q;
  assign vm_o      = vm_q;
  assign beat_o    = issue_cnt_q;
  assign id_o      = id_q;
  // Word address of the current beat inside vd
  assign addr_o    = AddrWidth'(vd_q) * AddrWidth'(VregWords) + AddrWidth'(issue_cnt_q);
  assign done_o    = done_q;
  assign done_id_o = done_id_q;

endmodule

`default_nettype wire

/* rtl/masku_alu.sv */
// Mask ALU, computes one beat of a mask-logical operation with vl and mask bit enables
`timescale 1ns/1ps
`default_nettype none

module masku_alu (
  input  masku_pkg::mask_op_e                op_i,
  input  logic [masku_pkg::VlWidth-1:0]      vl_i,
  input  logic                               vm_i,
  input  logic [masku_pkg::BeatCntWidth-1:0] beat_i,
  // Flat beat operands, lane l at bits 64*l and up
  input  logic [masku_pkg::BeatWidth-1:0]    opa_i,
  input  logic [masku_pkg::BeatWidth-1:0]    opb_i,
  input  logic [masku_pkg::BeatWidth-1:0]    old_i,
  input  logic [masku_pkg::BeatWidth-1:0]    mask_i,
  output logic [masku_pkg::BeatWidth-1:0]    result_o,
  output logic [masku_pkg::BeatStrb-1:0]     be_o
);
  import masku_pkg::*;

  logic [VlWidth-1:0]   beat_base;
  logic [VlWidth-1:0]   remaining;
  logic [BeatWidth-1:0] vl_en;
  logic [BeatWidth-1:0] bit_en;
  logic [BeatWidth-1:0] op_res;

  // First global bit index of this beat
  assign beat_base = VlWidth'(beat_i) << BeatShift;
  // Bits of the vector that fall into this beat or later
  assign remaining = (vl_i > beat_base) ? (vl_i - beat_base) : '0;

  ////////////////////////////////////////
  // Bit and byte enables
  ////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 0; i < BeatWidth; i++) begin
      vl_en[i] = VlWidth'(i) < remaining;
    end
  end

  // Masked instruction, inactive bits keep vd
  assign bit_en = vm_i ? vl_en : (vl_en & mask_i);

  // Byte is written when its first bit lies below vl
  always_comb begin
    for (int unsigned k = 0; k < BeatStrb; k++) begin
      be_o[k] = VlWidth'(k * (LaneWidth / LaneStrb)) < remaining;
    end
  end

  ////////////////////////////////////////
  // Logical operation
  ////////////////////////////////////////

  always_comb begin
    unique case (op_i)
      VMAND:   op_res = opa_i & opb_i;
      VMNAND:  op_res = ~(opa_i & opb_i);
      VMANDN:  op_res = opa_i & ~opb_i;
      VMXOR:   op_res = opa_i ^ opb_i;
      VMOR:    op_res = opa_i | opb_i;
      VMNOR:   op_res = ~(opa_i | opb_i);
      VMORN:   op_res = opa_i | ~opb_i;
      VMXNOR:  op_res = ~(opa_i ^ opb_i);
      default: op_res = '0;
    endcase
  end

  // Merge with the old destination bit by bit
  assign result_o = (op_res & bit_en) | (old_i & ~bit_en);

endmodule

`default_nettype wire

/* rtl/masku_result_queue.sv */
// Mask unit result queue, two beats deep, written back per lane through request and grant
`timescale 1ns/1ps
`default_nettype none

module masku_result_queue (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Push side from the ALU
  input  logic                                                       push_i,
  input  logic [masku_pkg::BeatWidth-1:0]                            wdata_i,
  input  logic [masku_pkg::BeatStrb-1:0]                             be_i,
  input  logic [masku_pkg::AddrWidth-1:0]                            addr_i,
  input  logic [masku_pkg::IdWidth-1:0]                              id_i,
  output logic                                                       full_o,
  output logic                                                       pop_o,
  // Register-file write per lane
  output logic [masku_pkg::NrLanes-1:0]                              result_req_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::AddrWidth-1:0]    result_addr_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::IdWidth-1:0]      result_id_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]    result_wdata_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneStrb-1:0]     result_be_o,
  input  logic [masku_pkg::NrLanes-1:0]                              result_gnt_i
);
  import masku_pkg::*;

  // Entry payload
  logic [ResultDepth-1:0][BeatWidth-1:0] wdata_q;
  logic [ResultDepth-1:0][BeatStrb-1:0]  be_q;
  logic [ResultDepth-1:0][AddrWidth-1:0] addr_q;
  logic [ResultDepth-1:0][IdWidth-1:0]   id_q;

  // One pending bit per lane and entry
  logic [ResultDepth-1:0][NrLanes-1:0]   valid_q;
  logic [RqPtrWidth-1:0]                 wr_ptr_q;
  logic [RqPtrWidth-1:0]                 rd_ptr_q;

  logic [ResultDepth-1:0]                entry_busy;
  logic [NrLanes-1:0]                    head_valid;
  logic [NrLanes-1:0]                    head_left;

  function automatic logic [RqPtrWidth-1:0] next_ptr(input logic [RqPtrWidth-1:0] ptr);
    next_ptr = (ptr == RqPtrWidth'(ResultDepth - 1)) ? '0 : ptr + RqPtrWidth'(1);
  endfunction

  ////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////

  // An entry stays busy until every lane has taken its word
  always_comb begin
    for (int unsigned e = 0; e < ResultDepth; e++) begin
      entry_busy[e] = |valid_q[e];
    end
  end

  assign full_o     = &entry_busy;
  assign head_valid = valid_q[rd_ptr_q];
  // Lanes still waiting after this cycle's grants
  assign head_left  = head_valid & ~result_gnt_i;
  // Last outstanding lane granted
  assign pop_o      = (|head_valid) && !(|head_left);

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[wr_ptr_q] <= wdata_i;
      be_q[wr_ptr_q]    <= be_i;
      addr_q[wr_ptr_q]  <= addr_i;
      id_q[wr_ptr_q]    <= id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      // Drop granted lanes of the head entry
      valid_q[rd_ptr_q] <= head_left;
      // A push only lands on a free entry, so it may follow the clear
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q          <= next_ptr(wr_ptr_q);
      end
      if (pop_o) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
    end
  end

  ////////////////////////////////////////
  // Lane outputs
  ////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane_out
    assign result_req_o[l]   = head_valid[l];
    assign result_addr_o[l]  = addr_q[rd_ptr_q];
    assign result_id_o[l]    = id_q[rd_ptr_q];
    // Lane l owns its 64-bit slice of the beat
    assign result_wdata_o[l] = wdata_q[rd_ptr_q][l*LaneWidth +: LaneWidth];
    assign result_be_o[l]    = be_q[rd_ptr_q][l*LaneStrb +: LaneStrb];
  end

endmodule

`default_nettype wire

/* rtl/masku.sv */
// Mask unit top level, joins lane operands and ties control, mask ALU and result queue
`timescale 1ns/1ps
`default_nettype none

module masku (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Sequencer
  input  logic                                                       req_valid_i,
  input  masku_pkg::mask_op_e                                        req_op_i,
  input  logic [masku_pkg::VlWidth-1:0]                              req_vl_i,
  input  logic [masku_pkg::VdWidth-1:0]                              req_vd_i,
  input  logic                                                       req_vm_i,
  input  logic [masku_pkg::IdWidth-1:0]                              req_id_i,
  output logic                                                       req_ready_o,
  output logic                                                       done_o,
  output logic [masku_pkg::IdWidth-1:0]                              done_id_o,
  // Lane operands
  input  logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]    opa_i,
  input  logic [masku_pkg::NrLanes-1:0]                              opa_valid_i,
  input  logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]    opb_i,
  input  logic [masku_pkg::NrLanes-1:0]                              opb_valid_i,
  input  logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]    old_i,
  input  logic [masku_pkg::NrLanes-1:0]                              old_valid_i,
  input  logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]    mask_i,
  input  logic [masku_pkg::NrLanes-1:0]                              mask_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                              operand_ready_o,
  // Lane results
  output logic [masku_pkg::NrLanes-1:0]                              result_req_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::AddrWidth-1:0]    result_addr_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::IdWidth-1:0]      result_id_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]    result_wdata_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneStrb-1:0]     result_be_o,
  input  logic [masku_pkg::NrLanes-1:0]                              result_gnt_i
);
  import masku_pkg::*;

  logic                    operands_valid;
  logic                    queue_full;
  logic                    queue_pop;
  logic                    issue;
  mask_op_e                op;
  logic [VlWidth-1:0]      vl;
  logic                    vm;
  logic [BeatCntWidth-1:0] beat;
  logic [AddrWidth-1:0]    addr;
  logic [IdWidth-1:0]      id;

  // Lane words laid side by side
  logic [BeatWidth-1:0]    opa_flat;
  logic [BeatWidth-1:0]    opb_flat;
  logic [BeatWidth-1:0]    old_flat;
  logic [BeatWidth-1:0]    mask_flat;
  logic [BeatWidth-1:0]    alu_result;
  logic [BeatStrb-1:0]     alu_be;

  // All lanes together, the mask only for a masked instruction
  assign operands_valid = (&opa_valid_i) && (&opb_valid_i) && (&old_valid_i) &&
                          (vm || (&mask_valid_i));
  // Every lane consumes its operands on the issue cycle
  assign operand_ready_o = {NrLanes{issue}};

  assign opa_flat  = opa_i;
  assign opb_flat  = opb_i;
  assign old_flat  = old_i;
  assign mask_flat = mask_i;

  masku_insn_ctrl masku_insn_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .req_op_i         (req_op_i),
    .req_vl_i         (req_vl_i),
    .req_vd_i         (req_vd_i),
    .req_vm_i         (req_vm_i),
    .req_id_i         (req_id_i),
    .req_ready_o      (req_ready_o),
    .operands_valid_i (operands_valid),
    .queue_full_i     (queue_full),
    .issue_o          (issue),
    .op_o             (op),
    .vl_o             (vl),
    .vm_o             (vm),
    .beat_o           (beat),
    .addr_o           (addr),
    .id_o             (id),
    .pop_i            (queue_pop),
    .done_o           (done_o),
    .done_id_o        (done_id_o)
  );

  masku_alu masku_alu_inst (
    .op_i     (op),
    .vl_i     (vl),
    .vm_i     (vm),
    .beat_i   (beat),
    .opa_i    (opa_flat),
    .opb_i    (opb_flat),
    .old_i    (old_flat),
    .mask_i   (mask_flat),
    .result_o (alu_result),
    .be_o     (alu_be)
  );

  // One entry per issued beat
  masku_result_queue masku_result_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (issue),
    .wdata_i        (alu_result),
    .be_i           (alu_be),
    .addr_i         (addr),
    .id_i           (id),
    .full_o         (queue_full),
    .pop_o          (queue_pop),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

`default_nettype wire

/* bench/masku_props.sv */
// Concurrent checks on the mask unit handshakes, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module masku_props (
  input logic                                                     clk_i,
  input logic                                                     rst_ni,
  input logic                                                     req_valid_i,
  input logic                                                     req_ready_i,
  input logic                                                     done_i,
  input logic [masku_pkg::NrLanes-1:0]                            result_req_i,
  input logic [masku_pkg::NrLanes-1:0]                            result_gnt_i,
  input logic [masku_pkg::NrLanes-1:0][masku_pkg::AddrWidth-1:0]  result_addr_i,
  input logic [masku_pkg::NrLanes-1:0][masku_pkg::IdWidth-1:0]    result_id_i,
  input logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneWidth-1:0]  result_wdata_i,
  input logic [masku_pkg::NrLanes-1:0][masku_pkg::LaneStrb-1:0]   result_be_i
);
  import masku_pkg::*;

  // Failed assertions, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // A waiting lane keeps its request and payload until the grant
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    a_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_i[l] && !result_gnt_i[l] |=> result_req_i[l] &&
        $stable({result_addr_i[l], result_id_i[l], result_wdata_i[l], result_be_i[l]}))
    else begin
      $error("Lane %0d result changed while waiting for its grant", l);
      fail_cnt++;
    end
  end

  // Done lasts exactly one cycle
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
  else begin
    $error("Done held high for two cycles");
    fail_cnt++;
  end

  // Busy right after an accepted request
  a_busy_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && req_ready_i |=> !req_ready_i)
  else begin
    $error("Ready stayed high after an accepted request");
    fail_cnt++;
  end

  // Ready only comes back together with done
  a_ready_with_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_ready_i ##1 req_ready_i |-> done_i)
  else begin
    $error("Ready returned without a done pulse");
    fail_cnt++;
  end

endmodule

bind masku masku_props masku_props_inst (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .req_ready_i    (req_ready_o),
  .done_i         (done_o),
  .result_req_i   (result_req_o),
  .result_gnt_i   (result_gnt_i),
  .result_addr_i  (result_addr_o),
  .result_id_i    (result_id_o),
  .result_wdata_i (result_wdata_o),
  .result_be_i    (result_be_o)
);

`default_nettype wire

/* bench/tb_masku.sv */
// Testbench for the mask unit, random lane traffic and grants checked against a bit-level model
`timescale 1ns/1ps
`default_nettype none

module tb_masku;
  import masku_pkg::*;

  localparam int unsigned NrInsn    = 40;
  localparam int unsigned WaitLimit = 2000;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               req_valid;
  mask_op_e                           req_op;
  logic [VlWidth-1:0]                 req_vl;
  logic [VdWidth-1:0]                 req_vd;
  logic                               req_vm;
  logic [IdWidth-1:0]                 req_id;
  logic                               req_ready;
  logic                               done;
  logic [IdWidth-1:0]                 done_id;
  logic [NrLanes-1:0][LaneWidth-1:0]  opa;
  logic [NrLanes-1:0][LaneWidth-1:0]  opb;
  logic [NrLanes-1:0][LaneWidth-1:0]  old;
  logic [NrLanes-1:0][LaneWidth-1:0]  mask;
  logic [NrLanes-1:0]                 opa_valid;
  logic [NrLanes-1:0]                 opb_valid;
  logic [NrLanes-1:0]                 old_valid;
  logic [NrLanes-1:0]                 mask_valid;
  logic [NrLanes-1:0]                 operand_ready;
  logic [NrLanes-1:0]                 result_req;
  logic [NrLanes-1:0][AddrWidth-1:0]  result_addr;
  logic [NrLanes-1:0][IdWidth-1:0]    result_id;
  logic [NrLanes-1:0][LaneWidth-1:0]  result_wdata;
  logic [NrLanes-1:0][LaneStrb-1:0]   result_be;
  logic [NrLanes-1:0]                 result_gnt;

  // Instruction under test
  mask_op_e             cur_op;
  logic [VlWidth-1:0]   cur_vl;
  logic [VdWidth-1:0]   cur_vd;
  logic                 cur_vm;
  logic [IdWidth-1:0]   cur_id;
  int unsigned          cur_beats;
  // Operands and model results per beat
  logic [BeatWidth-1:0] beat_opa [VregWords];
  logic [BeatWidth-1:0] beat_opb [VregWords];
  logic [BeatWidth-1:0] beat_old [VregWords];
  logic [BeatWidth-1:0] beat_mask [VregWords];
  logic [BeatWidth-1:0] exp_data [VregWords];
  logic [BeatStrb-1:0]  exp_be [VregWords];
  // Lane traffic state
  int unsigned          lane_beat [NrLanes];
  int unsigned          lane_wait [NrLanes];
  int unsigned          rx_cnt [NrLanes];
  logic [NrLanes-1:0]   consumed;
  logic                 start_req;
  logic                 expect_done;
  int unsigned          insn_cnt;
  int unsigned          done_cnt;
  int unsigned          check_cnt;
  int unsigned          err_cnt;
  int unsigned          timeout_cnt;

  masku masku_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_op_i        (req_op),
    .req_vl_i        (req_vl),
    .req_vd_i        (req_vd),
    .req_vm_i        (req_vm),
    .req_id_i        (req_id),
    .req_ready_o     (req_ready),
    .done_o          (done),
    .done_id_o       (done_id),
    .opa_i           (opa),
    .opa_valid_i     (opa_valid),
    .opb_i           (opb),
    .opb_valid_i     (opb_valid),
    .old_i           (old),
    .old_valid_i     (old_valid),
    .mask_i          (mask),
    .mask_valid_i    (mask_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_addr_o   (result_addr),
    .result_id_o     (result_id),
    .result_wdata_o  (result_wdata),
    .result_be_o     (result_be),
    .result_gnt_i    (result_gnt)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Checking and end of run
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [BeatWidth-1:0] got,
                             input logic [BeatWidth-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t ns: %s mismatch, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_and_finish();
    int unsigned total_err;
    total_err = err_cnt + masku_inst.masku_props_inst.fail_cnt;
    $display("Instructions %0d, checks %0d, errors %0d, timeouts %0d",
             insn_cnt, check_cnt, total_err, timeout_cnt);
    if (total_err == 0 && timeout_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    timeout_cnt++;
    report_and_finish();
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [BeatWidth-1:0] random_beat();
    logic [BeatWidth-1:0] v;
    for (int i = 0; i < BeatWidth / 32; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  // Truth table of each opcode, a is vs2 and b is vs1
  function automatic logic op_bit(input mask_op_e op, input logic a, input logic b);
    case (op)
      VMAND:   return a & b;
      VMNAND:  return !(a & b);
      VMANDN:  return a & !b;
      VMXOR:   return a ^ b;
      VMOR:    return a | b;
      VMNOR:   return !(a | b);
      VMORN:   return a | !b;
      default: return !(a ^ b);
    endcase
  endfunction

  // First eight instructions walk the opcodes at full length, the rest are random
  task automatic build_insn(input int unsigned n);
    int unsigned gidx;
    logic        active;
    cur_op    = (n < 8) ? mask_op_e'(n) : mask_op_e'($urandom % 8);
    cur_vl    = (n < 8) ? VlWidth'(1024) : VlWidth'(1 + $urandom % 1024);
    cur_vm    = (n < 8) ? 1'b1 : 1'($urandom % 2);
    cur_vd    = VdWidth'($urandom);
    cur_id    = IdWidth'(n);
    cur_beats = (cur_vl + BeatWidth - 1) / BeatWidth;
    for (int b = 0; b < cur_beats; b++) begin
      beat_opa[b]  = random_beat();
      beat_opb[b]  = random_beat();
      beat_old[b]  = random_beat();
      beat_mask[b] = random_beat();
      for (int i = 0; i < BeatWidth; i++) begin
        gidx   = b * BeatWidth + i;
        active = (gidx < cur_vl) && (cur_vm || beat_mask[b][i]);
        exp_data[b][i] = active ? op_bit(cur_op, beat_opa[b][i], beat_opb[b][i]) :
                                  beat_old[b][i];
      end
      // A byte is written when its first bit lies below vl
      for (int k = 0; k < BeatStrb; k++) begin
        exp_be[b][k] = (b * BeatWidth + k * 8) < cur_vl;
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus, driven 2 ns after the rising edge
  ////////////////////////////////////////

  task automatic drive_request();
    req_valid = 1'b0;
    if (start_req) begin
      req_valid = 1'b1;
      req_op    = cur_op;
      req_vl    = cur_vl;
      req_vd    = cur_vd;
      req_vm    = cur_vm;
      req_id    = cur_id;
      start_req = 1'b0;
      for (int l = 0; l < NrLanes; l++) begin
        lane_beat[l] = 0;
        lane_wait[l] = $urandom % 4;
        rx_cnt[l]    = 0;
      end
    end
  endtask

  task automatic drive_operands();
    logic on;
    for (int l = 0; l < NrLanes; l++) begin
      if (consumed[l]) begin
        lane_beat[l]++;
        lane_wait[l] = $urandom % 4;
      end else if (lane_wait[l] != 0) begin
        lane_wait[l]--;
      end
      on = (lane_beat[l] < cur_beats) && (lane_wait[l] == 0);
      opa_valid[l]  = on;
      opb_valid[l]  = on;
      old_valid[l]  = on;
      // Unmasked instructions must not wait for the mask
      mask_valid[l] = on && !cur_vm;
      if (lane_beat[l] < cur_beats) begin
        opa[l]  = beat_opa[lane_beat[l]][l*LaneWidth +: LaneWidth];
        opb[l]  = beat_opb[lane_beat[l]][l*LaneWidth +: LaneWidth];
        old[l]  = beat_old[lane_beat[l]][l*LaneWidth +: LaneWidth];
        mask[l] = beat_mask[lane_beat[l]][l*LaneWidth +: LaneWidth];
      end
    end
  endtask

  always @(posedge clk_i) begin
    #2;
    drive_request();
    drive_operands();
    for (int l = 0; l < NrLanes; l++) begin
      result_gnt[l] = ($urandom % 4) != 0;
    end
  end

  ////////////////////////////////////////
  // Monitor, sampled at the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    logic        granted;
    logic        all_in;
    int unsigned b;
    if (rst_ni) begin
      granted = 1'b0;
      all_in  = 1'b1;
      // Done is due one cycle after the last entry left
      check_value("done", done, expect_done);
      if (done) begin
        check_value("done id", done_id, cur_id);
        done_cnt++;
      end
      for (int l = 0; l < NrLanes; l++) begin
        consumed[l] = operand_ready[l];
        if (operand_ready[l]) begin
          check_value($sformatf("lane %0d operand valid at ready", l), opa_valid[l], 1'b1);
        end
        if (result_req[l] && result_gnt[l]) begin
          granted = 1'b1;
          if (rx_cnt[l] >= cur_beats) begin
            err_cnt++;
            $display("Lane %0d wrote a beat that was never issued at %0t ns", l, $time);
          end else begin
            b = rx_cnt[l];
            check_value($sformatf("lane %0d beat %0d data", l, b), result_wdata[l],
                        exp_data[b][l*LaneWidth +: LaneWidth]);
            check_value($sformatf("lane %0d beat %0d strobe", l, b), result_be[l],
                        exp_be[b][l*LaneStrb +: LaneStrb]);
            check_value($sformatf("lane %0d beat %0d address", l, b), result_addr[l],
                        cur_vd * VregWords + b);
            check_value($sformatf("lane %0d beat %0d id", l, b), result_id[l], cur_id);
            rx_cnt[l]++;
          end
        end
        if (rx_cnt[l] != cur_beats) begin
          all_in = 1'b0;
        end
      end
      expect_done = granted && all_in;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int unsigned cycles;
    void'($urandom(27));
    rst_ni      = 1'b0;
    req_valid   = 1'b0;
    req_op      = VMAND;
    req_vl      = '0;
    req_vd      = '0;
    req_vm      = 1'b0;
    req_id      = '0;
    opa         = '0;
    opb         = '0;
    old         = '0;
    mask        = '0;
    opa_valid   = '0;
    opb_valid   = '0;
    old_valid   = '0;
    mask_valid  = '0;
    result_gnt  = '0;
    cur_beats   = 0;
    consumed    = '0;
    start_req   = 1'b0;
    expect_done = 1'b0;
    insn_cnt    = 0;
    done_cnt    = 0;
    check_cnt   = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Quiet outputs after reset
    @(negedge clk_i);
    check_value("ready after reset", req_ready, 1'b1);
    check_value("result request after reset", result_req, '0);
    check_value("operand ready after reset", operand_ready, '0);

    for (int unsigned n = 0; n < NrInsn; n++) begin
      cycles = 0;
      @(negedge clk_i);
      while (!req_ready) begin
        if (cycles == WaitLimit) begin
          stop_on_timeout("request ready");
        end
        cycles++;
        @(negedge clk_i);
      end
      @(posedge clk_i);
      build_insn(n);
      start_req = 1'b1;
      insn_cnt++;
      cycles = 0;
      while (done_cnt != insn_cnt) begin
        if (cycles == WaitLimit) begin
          stop_on_timeout($sformatf("done of instruction %0d", n));
        end
        cycles++;
        @(posedge clk_i);
      end
      // Every beat written exactly once
      for (int l = 0; l < NrLanes; l++) begin
        check_value($sformatf("lane %0d beat count", l), rx_cnt[l], cur_beats);
      end
    end
    repeat (4) @(posedge clk_i);
    check_value("done count", done_cnt, insn_cnt);
    report_and_finish();
  end

endmodule

`default_nettype wire

/* masku.f */
rtl/masku_pkg.sv
rtl/masku_insn_ctrl.sv
rtl/masku_alu.sv
rtl/masku_result_queue.sv
rtl/masku.sv
bench/masku_props.sv
bench/tb_masku.sv
